//--- rtl/cr16Pkg.sv
// Shared widths, opcodes, flag positions and pipeline records
// for the CR16-style execute stage
package cr16Pkg;

   localparam int wordW     = 16;          // Data path width
   localparam int regIdxW   = 4;           // Register index width
   localparam int numRegs   = 16;          // Register file depth
   localparam int signBit   = wordW - 1;   // MSB of a word
   localparam int shiftAmtW = 5;           // Signed shift amount field
   localparam int psrW      = 5;           // C F L Z N

   typedef logic [wordW-1:0]   wordT;
   typedef logic [regIdxW-1:0] regIdxT;
   typedef logic [3:0]         aluOpT;
   typedef logic [psrW-1:0]    psrT;

   // ALU operation codes
   localparam aluOpT opAdd = 4'd0;   // Dest + src
   localparam aluOpT opSub = 4'd1;   // Dest - src
   localparam aluOpT opAnd = 4'd2;
   localparam aluOpT opXor = 4'd3;
   localparam aluOpT opOr  = 4'd4;
   localparam aluOpT opCmp = 4'd5;   // Flags only, no write-back
   localparam aluOpT opMov = 4'd6;   // Src into dest
   localparam aluOpT opLsh = 4'd7;   // Logical shift of dest
   localparam aluOpT opAsh = 4'd8;   // Arithmetic shift of dest

   // Status register bit positions
   localparam int flagC = 0;   // Carry / borrow
   localparam int flagF = 1;   // Signed overflow
   localparam int flagL = 2;   // Unsigned less than
   localparam int flagZ = 3;   // Equal
   localparam int flagN = 4;   // Signed less than

   // Instruction entering the execute stage
   typedef struct packed
   {
      aluOpT  op;
      regIdxT rDest;
      regIdxT rSrc;
      logic   useImm;   // Take imm instead of rSrc
      wordT   imm;      // Already sign-extended
   } execInstT;

   // Result record leaving the execute stage
   typedef struct packed
   {
      regIdxT rDest;
      wordT   value;
      psrT    psr;     // Status after this instruction
      logic   wrote;   // Low for compare
   } execResT;

endpackage

//--- rtl/regFile.sv
// Sixteen-entry register file
// Two combinational read ports, one synchronous write port
module regFile
(
   input  logic            clk,
   input  logic            arstN,
   input  cr16Pkg::regIdxT rdAddrA,
   output cr16Pkg::wordT   rdDataA,
   input  cr16Pkg::regIdxT rdAddrB,
   output cr16Pkg::wordT   rdDataB,
   input  logic            wrEn,
   input  cr16Pkg::regIdxT wrAddr,
   input  cr16Pkg::wordT   wrData
);
   import cr16Pkg::*;

   wordT regs [numRegs];   // Architectural registers

   // All registers read as zero after reset
   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         for (int i = 0; i < numRegs; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (wrEn)
      begin
         regs[wrAddr] <= wrData;   // Visible after this edge
      end
   end

   // Pipeline forwards around these reads
   assign rdDataA = regs[rdAddrA];   // Dest operand port
   assign rdDataB = regs[rdAddrB];   // Source operand port

endmodule

//--- rtl/alu.sv
// Arithmetic, logic, compare and move unit with flag generation
module alu
(
   input  cr16Pkg::aluOpT op,
   input  cr16Pkg::wordT  rDest,
   input  cr16Pkg::wordT  rSrc,
   input  cr16Pkg::psrT   psrIn,
   output cr16Pkg::wordT  result,
   output cr16Pkg::psrT   psrOut
);
   import cr16Pkg::*;

   logic [wordW:0] sumW;    // Sum with carry out
   logic [wordW:0] diffW;   // Difference with borrow
   logic           destNeg;
   logic           srcNeg;

   assign sumW    = {1'b0, rDest} + {1'b0, rSrc};
   assign diffW   = {1'b0, rDest} - {1'b0, rSrc};   // Borrow lands in top bit
   assign destNeg = rDest[signBit];
   assign srcNeg  = rSrc[signBit];

   always_comb
   begin
      result = '0;
      psrOut = psrIn;   // Undefined flags hold
      case (op)
         opAdd:
         begin
            result        = sumW[wordW-1:0];
            psrOut[flagC] = sumW[wordW];
            // Same-sign operands with a flipped result sign
            psrOut[flagF] = (destNeg == srcNeg) && (result[signBit] != destNeg);
         end
         opSub:
         begin
            result        = diffW[wordW-1:0];
            psrOut[flagC] = diffW[wordW];   // Borrow
            psrOut[flagF] = (destNeg != srcNeg) && (result[signBit] != destNeg);
         end
         opAnd:
         begin
            result = rDest & rSrc;
         end
         opXor:
         begin
            result = rDest ^ rSrc;
         end
         opOr:
         begin
            result = rDest | rSrc;
         end
         opCmp:
         begin
            result        = diffW[wordW-1:0];   // Dropped by pipeline
            psrOut[flagL] = rDest < rSrc;       // Unsigned
            psrOut[flagZ] = rDest == rSrc;
            psrOut[flagN] = $signed(rDest) < $signed(rSrc);
         end
         opMov:
         begin
            result = rSrc;
         end
         default:
         begin
            result = '0;   // Shifts come from the shifter
         end
      endcase
   end

endmodule

//--- rtl/shifter.sv
// Logical and arithmetic shifter driven by a signed amount
// Positive shifts left, negative shifts right
module shifter
(
   input  cr16Pkg::wordT value,
   input  cr16Pkg::wordT amount,
   input  logic          arith,
   output cr16Pkg::wordT shifted
);
   import cr16Pkg::*;

   logic signed [shiftAmtW-1:0] amt;    // Signed low bits of source
   logic        [shiftAmtW-1:0] mag;    // Shift distance 0..16
   logic                        right;  // Negative amount
   logic                        fill;   // Bit shifted in from the left

   assign amt   = amount[shiftAmtW-1:0];
   assign right = amt[shiftAmtW-1];
   assign mag   = right ? shiftAmtW'(-amt) : amt;   // -16 maps to 16
   assign fill  = arith & value[signBit];

   always_comb
   begin
      if (mag >= shiftAmtW'(wordW))
      begin
         // Whole word shifted out
         shifted = right ? {wordW{fill}} : '0;
      end
      else if (right && arith)
      begin
         shifted = wordT'($signed(value) >>> mag);   // Sign fill
      end
      else if (right)
      begin
         shifted = value >> mag;   // Zero fill
      end
      else
      begin
         shifted = value << mag;
      end
   end

endmodule

//--- rtl/execPipe.sv
// Two-stage execute pipeline with operand forwarding,
// status register and output back-pressure
module execPipe
(
   input  logic              clk,
   input  logic              arstN,
   input  cr16Pkg::execInstT inst,
   input  logic              inValid,
   output logic              inReady,
   output cr16Pkg::execResT  res,
   output logic              outValid,
   input  logic              outReady,
   output cr16Pkg::regIdxT   rdAddrA,
   output cr16Pkg::regIdxT   rdAddrB,
   input  cr16Pkg::wordT     rdDataA,
   input  cr16Pkg::wordT     rdDataB,
   output logic              wrEn,
   output cr16Pkg::regIdxT   wrAddr,
   output cr16Pkg::wordT     wrData,
   output cr16Pkg::aluOpT    aluOp,
   output cr16Pkg::wordT     opDest,
   output cr16Pkg::wordT     opSrc,
   output cr16Pkg::psrT      psrCur,
   input  cr16Pkg::wordT     aluResult,
   input  cr16Pkg::psrT      aluPsr,
   input  cr16Pkg::wordT     shiftResult,
   output logic              shiftArith
);
   import cr16Pkg::*;

   logic     advance;     // Whole pipe moves this edge
   logic     fire;        // Stage A retires this edge
   logic     aValid;
   execInstT aInst;
   wordT     aDest;       // Dest operand value
   wordT     aSrc;        // Source value or immediate
   logic     bValid;
   execResT  bRes;
   psrT      psr;         // Processor status register
   logic     isShift;
   wordT     execValue;
   wordT     fwdDest;
   wordT     fwdSrc;

   assign advance = !bValid || outReady;
   assign inReady = advance;
   assign fire    = advance && aValid;

   // Stage A feeds the execution units
   assign aluOp      = aInst.op;
   assign opDest     = aDest;
   assign opSrc      = aSrc;
   assign psrCur     = psr;
   assign shiftArith = (aInst.op == opAsh);
   assign isShift    = (aInst.op == opLsh) || (aInst.op == opAsh);
   assign execValue  = isShift ? shiftResult : aluResult;

   assign wrEn   = fire && (aInst.op != opCmp);   // Compare never writes
   assign wrAddr = aInst.rDest;
   assign wrData = execValue;

   // Operand read for the incoming instruction bypasses the
   // register write that happens on the same edge
   assign rdAddrA = inst.rDest;
   assign rdAddrB = inst.rSrc;
   assign fwdDest = (wrEn && (wrAddr == inst.rDest)) ? wrData : rdDataA;
   assign fwdSrc  = (wrEn && (wrAddr == inst.rSrc)) ? wrData : rdDataB;

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         aValid <= 1'b0;
         bValid <= 1'b0;
         psr    <= '0;
      end
      else if (advance)
      begin
         aValid <= inValid;
         bValid <= aValid;
         if (aValid)
         begin
            psr <= aluPsr;   // Shifts pass psr through unchanged
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (advance && inValid)
      begin
         aInst <= inst;
         aDest <= fwdDest;
         aSrc  <= inst.useImm ? inst.imm : fwdSrc;
      end
      if (fire)
      begin
         bRes.rDest <= aInst.rDest;
         bRes.value <= execValue;
         bRes.psr   <= aluPsr;
         bRes.wrote <= (aInst.op != opCmp);
      end
   end

   assign res      = bRes;     // Held while stalled
   assign outValid = bValid;

endmodule

//--- rtl/cr16Exec.sv
// Execute stage top level
// Pipeline, register file, ALU and shifter
module cr16Exec
(
   input  logic              clk,
   input  logic              arstN,
   input  cr16Pkg::execInstT inst,
   input  logic              inValid,
   output logic              inReady,
   output cr16Pkg::execResT  res,
   output logic              outValid,
   input  logic              outReady
);
   import cr16Pkg::*;

   regIdxT rdAddrA;
   regIdxT rdAddrB;
   wordT   rdDataA;
   wordT   rdDataB;
   logic   wrEn;
   regIdxT wrAddr;
   wordT   wrData;
   aluOpT  aluOp;
   wordT   opDest;      // Stage A dest operand
   wordT   opSrc;       // Stage A source operand
   psrT    psrCur;
   wordT   aluResult;
   psrT    aluPsr;
   wordT   shiftResult;
   logic   shiftArith;

   execPipe uPipe
   (
      .clk, .arstN,
      .inst, .inValid, .inReady,
      .res, .outValid, .outReady,
      .rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
      .wrEn, .wrAddr, .wrData,
      .aluOp, .opDest, .opSrc, .psrCur,
      .aluResult, .aluPsr, .shiftResult, .shiftArith
   );

   regFile uRegs
   (
      .clk, .arstN,
      .rdAddrA, .rdDataA,
      .rdAddrB, .rdDataB,
      .wrEn, .wrAddr, .wrData
   );

   alu uAlu
   (
      .op(aluOp), .rDest(opDest), .rSrc(opSrc), .psrIn(psrCur),
      .result(aluResult), .psrOut(aluPsr)
   );

   shifter uShift
   (
      .value(opDest), .amount(opSrc), .arith(shiftArith),
      .shifted(shiftResult)
   );

endmodule

//--- bench/cr16Exec_assert.sv
// Handshake assertions for the execute stage top level
module cr16Exec_assert
(
   input logic             clk,
   input logic             arstN,
   input logic             inReady,
   input cr16Pkg::execResT res,
   input logic             outValid,
   input logic             outReady
);

   // Stalled result stays valid and unchanged
   resHeld: assert property (@(posedge clk) disable iff (!arstN)
      outValid && !outReady |=> outValid && $stable(res))
      else $error("Result changed or vanished while the output was stalled");

   // Both stages hold while the output is blocked
   stallBlocksInput: assert property (@(posedge clk) disable iff (!arstN)
      outValid && !outReady |-> !inReady)
      else $error("inReady high while the output was stalled");

   // Pipe comes out of reset empty
   resetEmpty: assert property (@(posedge clk)
      !arstN |=> !outValid)
      else $error("outValid high right after reset");

   // Empty pipe takes instructions
   resetReady: assert property (@(posedge clk)
      !arstN |-> inReady)
      else $error("inReady low during reset");

endmodule

//--- bench/cr16ExecTb.sv
// Testbench for the execute stage
// Directed table, random stream against a model, back-pressure and latency checks
module cr16ExecTb;
   import cr16Pkg::*;

   localparam int numDir       = 32;
   localparam int numRand      = 300;
   localparam int timeoutLimit = 4 * (numDir + numRand) + 200;

   // Directed entry with its expected record
   typedef struct packed
   {
      execInstT inst;
      wordT     value;   // Ignored for compare
      psrT      psr;
      logic     wrote;
   } vecT;

   logic     clk;
   logic     arstN;
   execInstT inst;
   logic     inValid;
   logic     inReady;
   execResT  res;
   logic     outValid;
   logic     outReady;
   logic     stallOn;            // Random outReady enable

   int       cycleCnt;
   int       checkCnt;
   int       errCnt;
   int       failCnt;            // Non-value failures
   int       resCnt;
   wordT     modelRegs [numRegs];
   psrT      modelPsr;
   execResT  expQ [$];           // Expected records in order
   int       accQ [$];           // Acceptance edge or -1 when untimed
   execResT  expRec;
   int       expAcc;

   // Instruction fields, then value, psr as NZLFC and wrote
   vecT dirTab [numDir] = '{
      '{'{opMov, 4'd1, 4'd0, 1'b1, 16'h7FFF}, 16'h7FFF, 5'b00000, 1'b1},
      '{'{opAdd, 4'd1, 4'd0, 1'b1, 16'h0001}, 16'h8000, 5'b00010, 1'b1},   // Signed overflow
      '{'{opMov, 4'd2, 4'd0, 1'b1, 16'hFFFF}, 16'hFFFF, 5'b00010, 1'b1},
      '{'{opAdd, 4'd2, 4'd0, 1'b1, 16'h0001}, 16'h0000, 5'b00001, 1'b1},   // Carry out
      '{'{opAdd, 4'd1, 4'd1, 1'b0, 16'h0000}, 16'h0000, 5'b00011, 1'b1},   // Carry and overflow
      '{'{opMov, 4'd3, 4'd0, 1'b1, 16'h0005}, 16'h0005, 5'b00011, 1'b1},
      '{'{opSub, 4'd3, 4'd0, 1'b1, 16'h0007}, 16'hFFFE, 5'b00001, 1'b1},   // Borrow
      '{'{opMov, 4'd4, 4'd0, 1'b1, 16'h8000}, 16'h8000, 5'b00001, 1'b1},
      '{'{opSub, 4'd4, 4'd0, 1'b1, 16'h0001}, 16'h7FFF, 5'b00010, 1'b1},   // Overflow
      '{'{opSub, 4'd3, 4'd3, 1'b0, 16'h0000}, 16'h0000, 5'b00000, 1'b1},
      '{'{opCmp, 4'd4, 4'd0, 1'b1, 16'h8000}, 16'h0000, 5'b00100, 1'b0},   // Unsigned less only
      '{'{opCmp, 4'd4, 4'd4, 1'b0, 16'h0000}, 16'h0000, 5'b01000, 1'b0},   // Equal
      '{'{opCmp, 4'd2, 4'd0, 1'b1, 16'hFFFF}, 16'h0000, 5'b00100, 1'b0},
      '{'{opCmp, 4'd1, 4'd0, 1'b1, 16'h0001}, 16'h0000, 5'b10100, 1'b0},   // Both less
      '{'{opMov, 4'd5, 4'd4, 1'b0, 16'h0000}, 16'h7FFF, 5'b10100, 1'b1},   // r4 kept by compares
      '{'{opMov, 4'd6, 4'd0, 1'b1, 16'h00F0}, 16'h00F0, 5'b10100, 1'b1},
      '{'{opAnd, 4'd6, 4'd0, 1'b1, 16'h0F3C}, 16'h0030, 5'b10100, 1'b1},
      '{'{opOr,  4'd6, 4'd0, 1'b1, 16'hA005}, 16'hA035, 5'b10100, 1'b1},
      '{'{opXor, 4'd6, 4'd0, 1'b1, 16'hFFFF}, 16'h5FCA, 5'b10100, 1'b1},
      '{'{opMov, 4'd7, 4'd0, 1'b1, 16'h8421}, 16'h8421, 5'b10100, 1'b1},
      '{'{opLsh, 4'd7, 4'd0, 1'b1, 16'h0004}, 16'h4210, 5'b10100, 1'b1},   // Left 4
      '{'{opLsh, 4'd7, 4'd0, 1'b1, 16'hFFFC}, 16'h0421, 5'b10100, 1'b1},   // Right 4
      '{'{opMov, 4'd8, 4'd0, 1'b1, 16'h8421}, 16'h8421, 5'b10100, 1'b1},
      '{'{opAsh, 4'd8, 4'd0, 1'b1, 16'hFFFE}, 16'hE108, 5'b10100, 1'b1},   // Sign fill
      '{'{opAsh, 4'd8, 4'd0, 1'b1, 16'h0010}, 16'hFFFF, 5'b10100, 1'b1},   // Right 16
      '{'{opLsh, 4'd7, 4'd0, 1'b1, 16'h000F}, 16'h8000, 5'b10100, 1'b1},   // Left 15
      '{'{opLsh, 4'd7, 4'd0, 1'b1, 16'h0010}, 16'h0000, 5'b10100, 1'b1},   // Zero fill 16
      '{'{opMov, 4'd9, 4'd0, 1'b1, 16'h4000}, 16'h4000, 5'b10100, 1'b1},
      '{'{opAsh, 4'd9, 4'd0, 1'b1, 16'h0001}, 16'h8000, 5'b10100, 1'b1},
      '{'{opAsh, 4'd9, 4'd0, 1'b1, 16'hFFF1}, 16'hFFFF, 5'b10100, 1'b1},   // Right 15
      '{'{opLsh, 4'd9, 4'd3, 1'b0, 16'h0000}, 16'hFFFF, 5'b10100, 1'b1},   // Zero amount
      '{'{opAdd, 4'd10, 4'd9, 1'b0, 16'h0000}, 16'hFFFF, 5'b10100, 1'b1}
   };

   cr16Exec UUT (.*);

   bind cr16Exec cr16Exec_assert uAssert
   (
      .clk(clk), .arstN(arstN), .inReady(inReady),
      .res(res), .outValid(outValid), .outReady(outReady)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycleCnt <= cycleCnt + 1;
   end

   initial
   begin
      outReady <= 1'b0;
      forever
      begin
         @(posedge clk);
         outReady <= stallOn ? 1'($urandom_range(0, 1)) : 1'b1;   // Random back-pressure
      end
   end

   task automatic checkWord(input string what, input wordT got, input wordT exp);
      checkCnt++;
      if (got !== exp)
      begin
         errCnt++;
         $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkIdx(input string what, input regIdxT got, input regIdxT exp);
      checkCnt++;
      if (got !== exp)
      begin
         errCnt++;
         $display("** Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic checkPsr(input string what, input psrT got, input psrT exp);
      checkCnt++;
      if (got !== exp)
      begin
         errCnt++;
         $display("** Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic checkBit(input string what, input logic got, input logic exp);
      checkCnt++;
      if (got !== exp)
      begin
         errCnt++;
         $display("** Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // Reference model of registers and status per instruction
   task automatic predict(input execInstT i, output execResT r);
      wordT d;
      wordT s;
      wordT v;
      psrT  p;
      int   wide;
      int   amt;
      logic fill;
      d = modelRegs[i.rDest];
      s = i.useImm ? i.imm : modelRegs[i.rSrc];
      v = d;
      p = modelPsr;   // Untouched flags carry over
      case (i.op)
         opAdd:
         begin
            wide     = int'(d) + int'(s);
            v        = wordT'(wide);
            p[flagC] = wide > 65535;
            p[flagF] = (d[signBit] == s[signBit]) && (v[signBit] != d[signBit]);
         end
         opSub:
         begin
            wide     = int'(d) - int'(s);
            v        = wordT'(wide);
            p[flagC] = wide < 0;   // Borrow
            p[flagF] = (d[signBit] != s[signBit]) && (v[signBit] != d[signBit]);
         end
         opCmp:
         begin
            p[flagL] = d < s;
            p[flagZ] = d == s;
            p[flagN] = $signed(d) < $signed(s);
         end
         opAnd: v = d & s;
         opXor: v = d ^ s;
         opOr:  v = d | s;
         opMov: v = s;
         default:
         begin
            amt  = int'(s[4:0]) - (s[4] ? 32 : 0);   // Signed 5-bit amount
            fill = (i.op == opAsh) && d[signBit];
            if (amt >= 0)
            begin
               v = d << amt;
            end
            for (int k = 0; k < -amt; k++)
            begin
               v = {fill, v[wordW-1:1]};   // One bit right per step
            end
         end
      endcase
      if (i.op != opCmp)
      begin
         modelRegs[i.rDest] = v;
      end
      modelPsr = p;
      r = '{i.rDest, v, p, i.op != opCmp};
   endtask

   // Present one instruction and wait for its acceptance edge
   task automatic sendInst(input execInstT i, input execResT e, input logic timed);
      inst    <= i;
      inValid <= 1'b1;
      @(posedge clk);
      while (!inReady)
      begin
         @(posedge clk);
      end
      expQ.push_back(e);
      accQ.push_back(timed ? cycleCnt : -1);
   endtask

   // Every output transfer against the next expected record
   always @(posedge clk)
   begin
      if (arstN && outValid && outReady)
      begin
         if (expQ.size() == 0)
         begin
            failCnt++;
            $display("A result arrived with no instruction outstanding at time %0t", $time);
         end
         else
         begin
            expRec = expQ.pop_front();
            expAcc = accQ.pop_front();
            checkIdx($sformatf("result %0d dest", resCnt), res.rDest, expRec.rDest);
            if (expRec.wrote)
            begin
               checkWord($sformatf("result %0d value", resCnt), res.value, expRec.value);
            end
            checkPsr($sformatf("result %0d psr", resCnt), res.psr, expRec.psr);
            checkBit($sformatf("result %0d wrote", resCnt), res.wrote, expRec.wrote);
            if (expAcc >= 0)
            begin
               checkBit($sformatf("result %0d latency of two edges", resCnt),
                        cycleCnt - expAcc == 2, 1'b1);
            end
            resCnt++;
         end
      end
   end

   initial
   begin
      wait (cycleCnt >= timeoutLimit);
      $display("Run stopped after %0d cycles with %0d results outstanding",
               cycleCnt, expQ.size());
      $display("STATUS: FAIL");
      $finish;
   end

   initial
   begin
      execInstT ri;
      execResT  re;
      execResT  modelRes;
      void'($urandom(32'hfaea26ea));
      arstN   <= 1'b0;
      inValid <= 1'b0;
      inst    <= '0;
      stallOn <= 1'b0;
      for (int r = 0; r < numRegs; r++)
      begin
         modelRegs[r] = '0;
      end
      modelPsr = '0;
      repeat (10) @(posedge clk);
      arstN <= 1'b1;
      @(posedge clk);

      // Directed table with outReady held high
      for (int n = 0; n < numDir; n++)
      begin
         re = '{dirTab[n].inst.rDest, dirTab[n].value, dirTab[n].psr, dirTab[n].wrote};
         predict(dirTab[n].inst, modelRes);   // Keeps model in step
         sendInst(dirTab[n].inst, re, 1'b1);
      end
      inValid <= 1'b0;
      while (expQ.size() != 0)
      begin
         @(posedge clk);
      end

      // Random stream under random back-pressure
      stallOn <= 1'b1;
      for (int n = 0; n < numRand; n++)
      begin
         if ($urandom_range(0, 7) == 0)
         begin
            inValid <= 1'b0;   // Idle gap
            @(posedge clk);
         end
         ri.op     = aluOpT'($urandom_range(0, 8));
         ri.rDest  = regIdxT'($urandom_range(0, 15));
         ri.rSrc   = regIdxT'($urandom_range(0, 15));
         ri.useImm = 1'($urandom_range(0, 1));
         ri.imm    = wordT'($urandom);
         predict(ri, re);
         sendInst(ri, re, 1'b0);
      end
      inValid <= 1'b0;
      while (expQ.size() != 0)
      begin
         @(posedge clk);
      end
      stallOn <= 1'b0;
      repeat (4) @(posedge clk);   // Catch stray results

      $display("Results %0d of %0d, checks %0d, value errors %0d, other failures %0d",
               resCnt, numDir + numRand, checkCnt, errCnt, failCnt);
      if (errCnt == 0 && failCnt == 0 && resCnt == numDir + numRand)
      begin
         $display("STATUS: PASS");
      end
      else
      begin
         if (resCnt != numDir + numRand)
         begin
            $display("The number of results does not match the instructions sent");
         end
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

//--- cr16Exec.f
rtl/cr16Pkg.sv
rtl/regFile.sv
rtl/alu.sv
rtl/shifter.sv
rtl/execPipe.sv
rtl/cr16Exec.sv
bench/cr16Exec_assert.sv
bench/cr16ExecTb.sv

//--- run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module cr16ExecTb -f cr16Exec.f

# The simulation status is decided from its output below
simOut=$(./obj_dir/Vcr16ExecTb 2>&1) || true
printf '%s\n' "$simOut"

if printf '%s\n' "$simOut" | grep -qx 'STATUS: PASS'
then
   exit 0
fi
echo "Simulation did not report a pass"
exit 1
